/* build.f */
verilog/icache_pkg.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_refill_ctrl.sv
verilog/icache_fetch_align.sv
verilog/icache_top.sv
test/tb_mem_model.sv
test/tb_icache.sv

/* run.sh */
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f build.f --top-module tb_icache -o tb_icache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_icache_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "^Test passed$" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1

/* test/tb_icache.sv */
`timescale 1ns/10ps

module tb_icache;

  localparam int num_lines = 128;
  localparam logic [31:0] seed = 32'h082397f0;
  localparam int max_gap = 3;
  localparam int reset_cycles = 5;
  // 1 cold fetch plus 32 hits plus 3 conflict and 2 uncached fetches
  localparam int num_fetches = 38;
  // slowest refill with lookup and tag write and response
  localparam int fetch_cycles = icache_pkg::beats_per_line * (max_gap + 1) + 6;
  localparam int timeout_cycles = reset_cycles + 2 * num_fetches * fetch_cycles;
  // line under test with its same index alias and a device word
  localparam logic [31:0] base = 32'h0000_1a40;
  localparam logic [31:0] alias_base = 32'h0000_3a40;
  localparam logic [31:0] dev_addr = 32'h1000_0124;

  logic clk;
  logic rst;
  logic fetch_valid;
  logic [31:0] fetch_addr;
  logic fetch_ready;
  logic rsp_valid;
  logic [31:0] rsp_inst;
  icache_pkg::mem_req_t mem_req;
  logic mem_req_valid;
  icache_pkg::mem_beat_t mem_beat;
  logic mem_beat_valid;
  int req_cnt;
  int err_cnt;
  int tests_run;
  int tests_failed;
  // instruction sizes seen
  int n16;
  int n32;
  int cycle_cnt;
  logic [31:0] rnd;
  // beats already taken for the request in flight
  int beats_got;
  // final beat of the current request
  logic last_beat;

  icache_top #(
    .num_lines (num_lines)
  ) dut_i (
    .clk              (clk),
    .rst              (rst),
    .fetch_valid_i    (fetch_valid),
    .fetch_addr_i     (fetch_addr),
    .fetch_ready_o    (fetch_ready),
    .rsp_valid_o      (rsp_valid),
    .rsp_inst_o       (rsp_inst),
    .mem_req_o        (mem_req),
    .mem_req_valid_o  (mem_req_valid),
    .mem_beat_i       (mem_beat),
    .mem_beat_valid_i (mem_beat_valid)
  );

  tb_mem_model #(
    .max_gap (max_gap),
    .seed    (seed)
  ) mem_i (
    .clk          (clk),
    .rst          (rst),
    .req_i        (mem_req),
    .req_valid_i  (mem_req_valid),
    .beat_o       (mem_beat),
    .beat_valid_o (mem_beat_valid),
    .req_cnt_o    (req_cnt)
  );

  always #2 clk = ~clk;

  // count starts over whenever the request is down
  always @(posedge clk) begin
    if (rst || !mem_req_valid) begin
      beats_got <= 0;
    end else if (mem_beat_valid) begin
      beats_got <= beats_got + 1;
    end
  end

  assign last_beat = mem_req_valid && mem_beat_valid && (beats_got == int'(mem_req.len));

  // response lasts one cycle and ready follows
  assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid && fetch_ready)
    else begin
      err_cnt++;
      $display("ERR %0t: response pulse not followed by ready", $time);
    end
  // request held constant until its last beat
  assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !last_beat |=> mem_req_valid && $stable(mem_req))
    else begin
      err_cnt++;
      $display("ERR %0t: memory request dropped or changed before its last beat", $time);
    end
  // request goes down right after the last beat
  assert property (@(posedge clk) disable iff (rst) last_beat |=> !mem_req_valid)
    else begin
      err_cnt++;
      $display("ERR %0t: memory request still up after its last beat", $time);
    end
  // device word answers in the cycle after its beat
  assert property (@(posedge clk) disable iff (rst)
    last_beat && (mem_req.len == 8'd0) |=> rsp_valid)
    else begin
      err_cnt++;
      $display("ERR %0t: no response in the cycle after the device beat", $time);
    end
  // refill writes the tag first and the lookup then hits
  assert property (@(posedge clk) disable iff (rst)
    $past(last_beat) && ($past(mem_req.len) != 8'd0) |=> rsp_valid)
    else begin
      err_cnt++;
      $display("ERR %0t: no response two cycles after the last refill beat", $time);
    end
  // idle means nothing in flight
  assert property (@(posedge clk) disable iff (rst) fetch_ready |-> !mem_req_valid && !rsp_valid)
    else begin
      err_cnt++;
      $display("ERR %0t: request or response while ready", $time);
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return xorshift32({2'b00, addr[31:2]});
  endfunction

  // little endian halfwords with the upper half zero past the end of the line
  function automatic logic [31:0] expect_inst(input logic [31:0] addr);
    logic [31:0] lo_word;
    logic [31:0] hi_word;
    logic [15:0] lo;
    logic [15:0] hi;
    lo_word = mem_word(addr);
    hi_word = mem_word(addr + 32'd2);
    lo = addr[1] ? lo_word[31:16] : lo_word[15:0];
    hi = addr[1] ? hi_word[15:0] : hi_word[31:16];
    if (addr[5:1] == 5'h1f) begin
      hi = 16'h0000;
    end
    return (lo[1:0] == 2'b11) ? {hi, lo} : {16'h0000, lo};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // one fetch with latency counted from the acceptance edge
  task automatic fetch(input logic [31:0] addr, output logic [31:0] inst, output int lat,
                       output logic req_seen, output icache_pkg::mem_req_t req);
    do @(negedge clk); while (!fetch_ready);
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_addr  <= addr;
    @(posedge clk);
    fetch_valid <= 1'b0;
    lat = 0;
    req_seen = 1'b0;
    req = '0;
    do begin
      @(negedge clk);
      lat++;
      // lookup cycle
      if (lat == 1) begin
        req_seen = mem_req_valid;
        req = mem_req;
      end
    end while (!rsp_valid);
    inst = rsp_inst;
  endtask

  task automatic cached_fetch(input logic [31:0] addr, input logic refill);
    logic [31:0] inst;
    logic [31:0] exp;
    int lat;
    logic req_seen;
    icache_pkg::mem_req_t req;
    int cnt_before;
    cnt_before = req_cnt;
    fetch(addr, inst, lat, req_seen, req);
    exp = expect_inst(addr);
    check_eq($sformatf("instruction at %h", addr), inst, exp);
    check_eq("request count", 32'(req_cnt - cnt_before), refill ? 32'd1 : 32'd0);
    check_eq("request at lookup", 32'(req_seen), 32'(refill));
    if (refill) begin
      check_eq("refill address", req.addr, {addr[31:6], 6'h00});
      check_eq("refill length", 32'(req.len), 32'd15);
    end else begin
      check_eq($sformatf("hit latency at %h", addr), 32'(lat), 32'd1);
    end
    if (exp[1:0] == 2'b11) n32++;
    else n16++;
  endtask

  task automatic uncached_fetch(input logic [31:0] addr);
    logic [31:0] inst;
    int lat;
    logic req_seen;
    icache_pkg::mem_req_t req;
    int cnt_before;
    cnt_before = req_cnt;
    fetch(addr, inst, lat, req_seen, req);
    check_eq($sformatf("device word at %h", addr), inst, mem_word(addr));
    check_eq("device request count", 32'(req_cnt - cnt_before), 32'd1);
    check_eq("device request at lookup", 32'(req_seen), 32'd1);
    check_eq("device request address", req.addr, addr);
    check_eq("device request length", 32'(req.len), 32'd0);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt != errs_before) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  initial begin : main_seq
    int errs;
    int start;
    logic [31:0] off;
    clk = 1'b0;
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    rnd = seed;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;

    // quiet outputs and ready in the first cycle
    errs = err_cnt;
    @(negedge clk);
    check_eq("ready after reset", 32'(fetch_ready), 32'd1);
    check_eq("response after reset", 32'(rsp_valid), 32'd0);
    check_eq("request after reset", 32'(mem_req_valid), 32'd0);
    end_test("reset", errs);

    // cold miss refills the whole line
    errs = err_cnt;
    rnd = xorshift32(rnd);
    off = {26'd0, rnd[4:0], 1'b0};
    cached_fetch(base + off, 1'b1);
    end_test("cold miss", errs);

    // every halfword of the line from a random start
    errs = err_cnt;
    n16 = 0;
    n32 = 0;
    rnd = xorshift32(rnd);
    start = int'(rnd[4:0]);
    for (int k = 0; k < 32; k++) begin
      cached_fetch(base + 32'(((start + k) % 32) * 2), 1'b0);
    end
    assert (n16 > 0 && n32 > 0) else begin
      err_cnt++;
      $display("line at %h did not give both 16 and 32 bit instructions", base);
    end
    end_test("hits", errs);

    // alias evicts and then the first line misses again
    errs = err_cnt;
    rnd = xorshift32(rnd);
    off = {26'd0, rnd[4:0], 1'b0};
    cached_fetch(alias_base + off, 1'b1);
    cached_fetch(base + off, 1'b1);
    cached_fetch(base + off, 1'b0);
    end_test("conflict", errs);

    // device word fetched again every time
    errs = err_cnt;
    uncached_fetch(dev_addr);
    uncached_fetch(dev_addr);
    end_test("uncached", errs);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still going after %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model #(
  parameter int          max_gap = 3,
  parameter logic [31:0] seed    = 32'h082397f0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  icache_pkg::mem_req_t  req_i,
  input  logic                  req_valid_i,
  output icache_pkg::mem_beat_t beat_o,
  output logic                  beat_valid_o,
  output int                    req_cnt_o
);

  // request valid last cycle, a burst starts on the rise only
  logic req_seen_q;
  logic busy_q;
  logic [31:0] addr_q;
  // beats still owed after the current one
  logic [7:0] left_q;
  int gap_q;
  logic [31:0] rnd_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // word contents follow from the whole word address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return xorshift32({2'b00, addr[31:2]});
  endfunction

  initial begin
    beat_o       = '0;
    beat_valid_o = 1'b0;
    req_cnt_o    = 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      req_seen_q   <= 1'b0;
      busy_q       <= 1'b0;
      beat_valid_o <= 1'b0;
      req_cnt_o    <= 0;
      gap_q        <= 0;
      rnd_q        <= seed;
    end else begin
      req_seen_q   <= req_valid_i;
      beat_valid_o <= 1'b0;
      rnd_q        <= xorshift32(rnd_q);
      if (!busy_q) begin
        if (req_valid_i && !req_seen_q) begin
          busy_q    <= 1'b1;
          addr_q    <= {req_i.addr[31:2], 2'b00};
          left_q    <= req_i.len;
          gap_q     <= int'(rnd_q % 32'(max_gap + 1));
          req_cnt_o <= req_cnt_o + 1;
          $display("mem: request %0d addr %h len %0d", req_cnt_o + 1, req_i.addr, req_i.len);
        end
      end else if (gap_q > 0) begin
        // idle cycles between beats
        gap_q <= gap_q - 1;
      end else begin
        beat_valid_o <= 1'b1;
        beat_o.data  <= mem_word(addr_q);
        addr_q       <= addr_q + 32'd4;
        gap_q        <= int'(rnd_q % 32'(max_gap + 1));
        if (left_q == 8'd0) begin
          busy_q <= 1'b0;
        end else begin
          left_q <= left_q - 8'd1;
        end
      end
    end
  end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/10ps

module icache_top #(
  parameter int num_lines = 128
) (
  input  logic                          clk,
  input  logic                          rst,
  // cpu fetch port
  input  logic                          fetch_valid_i,
  input  logic [icache_pkg::addr_w-1:0] fetch_addr_i,
  output logic                          fetch_ready_o,
  output logic                          rsp_valid_o,
  output logic [icache_pkg::beat_w-1:0] rsp_inst_o,
  // memory read port
  output icache_pkg::mem_req_t          mem_req_o,
  output logic                          mem_req_valid_o,
  input  icache_pkg::mem_beat_t         mem_beat_i,
  input  logic                          mem_beat_valid_i
);

  // registered fetch address, fanned out to both stores
  logic [icache_pkg::addr_w-1:0] lookup_addr;
  logic hit;
  logic tag_we;
  logic beat_we;
  logic [$clog2(icache_pkg::beats_per_line)-1:0] beat_idx;
  // indexed line toward the aligner
  logic [icache_pkg::line_w-1:0] line;
  logic [icache_pkg::beat_w-1:0] uncached_word;
  icache_pkg::fetch_src_e src;

  // sequencing and memory burst control
  icache_refill_ctrl ctrl_i (
    .clk              (clk),
    .rst              (rst),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_addr_i     (fetch_addr_i),
    .fetch_ready_o    (fetch_ready_o),
    .hit_i            (hit),
    .lookup_addr_o    (lookup_addr),
    .tag_we_o         (tag_we),
    .beat_we_o        (beat_we),
    .beat_idx_o       (beat_idx),
    .mem_req_o        (mem_req_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_beat_valid_i (mem_beat_valid_i),
    .mem_beat_i       (mem_beat_i),
    .uncached_word_o  (uncached_word),
    .src_o            (src),
    .rsp_valid_o      (rsp_valid_o)
  );

  // tags and valid bits
  icache_tag_store #(
    .num_lines (num_lines)
  ) tag_i (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .tag_we_i      (tag_we),
    .hit_o         (hit)
  );

  // line data, filled beat by beat
  icache_data_store #(
    .num_lines (num_lines)
  ) data_i (
    .clk           (clk),
    .lookup_addr_i (lookup_addr),
    .beat_we_i     (beat_we),
    .beat_idx_i    (beat_idx),
    .beat_i        (mem_beat_i),
    .line_o        (line)
  );

  // instruction extraction, offset from the registered address
  icache_fetch_align align_i (
    .line_i          (line),
    .line_off_i      (lookup_addr[icache_pkg::line_off_w-1:0]),
    .src_i           (src),
    .uncached_word_i (uncached_word),
    .inst_o          (rsp_inst_o)
  );

endmodule

/* verilog/icache_fetch_align.sv */
`timescale 1ns/10ps

module icache_fetch_align (
  input  logic [icache_pkg::line_w-1:0]     line_i,
  input  logic [icache_pkg::line_off_w-1:0] line_off_i,
  input  icache_pkg::fetch_src_e            src_i,
  input  logic [icache_pkg::beat_w-1:0]     uncached_word_i,
  output logic [icache_pkg::beat_w-1:0]     inst_o
);

  // halfword index inside the line, 32 halfwords per line
  localparam int hw_idx_w = icache_pkg::line_off_w - 1;

  logic [hw_idx_w-1:0] hw_idx;
  logic [hw_idx_w-1:0] nxt_idx;
  logic                last_hw;
  logic [15:0]         lo_hw;
  logic [15:0]         hi_hw;
  logic                is_32;
  logic [31:0]         cache_inst;

  // byte offset bit 0 is ignored, instructions are halfword aligned
  assign hw_idx = line_off_i[icache_pkg::line_off_w-1:1];
  // wraps at the end of the line, masked below
  assign nxt_idx = hw_idx + 1'b1;
  assign last_hw = &hw_idx;

  // first halfword of the instruction
  assign lo_hw = line_i[hw_idx*16 +: 16];
  // upper half only exists inside this line
  assign hi_hw = last_hw ? 16'h0000 : line_i[nxt_idx*16 +: 16];

  // rvc: low bits 11 mean a full 32 bit encoding
  assign is_32 = lo_hw[1:0] == 2'b11;

  // compressed forms come back zero extended
  assign cache_inst = is_32 ? {hi_hw, lo_hw} : {16'h0000, lo_hw};

  // device words pass through untouched
  assign inst_o = (src_i == icache_pkg::src_uncached) ? uncached_word_i : cache_inst;

endmodule

/* verilog/icache_refill_ctrl.sv */
`timescale 1ns/10ps

module icache_refill_ctrl (
  input  logic                                          clk,
  input  logic                                          rst,
  // cpu side
  input  logic                                          fetch_valid_i,
  input  logic [icache_pkg::addr_w-1:0]                 fetch_addr_i,
  output logic                                          fetch_ready_o,
  // tag and data stores
  input  logic                                          hit_i,
  output logic [icache_pkg::addr_w-1:0]                 lookup_addr_o,
  output logic                                          tag_we_o,
  output logic                                          beat_we_o,
  output logic [$clog2(icache_pkg::beats_per_line)-1:0] beat_idx_o,
  // memory side
  output icache_pkg::mem_req_t                          mem_req_o,
  output logic                                          mem_req_valid_o,
  input  logic                                          mem_beat_valid_i,
  input  icache_pkg::mem_beat_t                         mem_beat_i,
  // aligner and response
  output logic [icache_pkg::beat_w-1:0]                 uncached_word_o,
  output icache_pkg::fetch_src_e                        src_o,
  output logic                                          rsp_valid_o
);

  icache_pkg::refill_state_e state_q;

  // registered fetch address, shared by both stores
  logic [icache_pkg::addr_w-1:0] addr_q;
  // refill beat counter
  logic [$clog2(icache_pkg::beats_per_line)-1:0] beat_cnt_q;
  // all beats taken, set the cycle after the last one
  logic done_q;
  // word from the device region
  logic [icache_pkg::beat_w-1:0] word_q;

  logic uncached;
  logic last_beat;

  // device region decode
  assign uncached = (addr_q & icache_pkg::uncached_mask) == icache_pkg::uncached_base;
  assign last_beat = beat_cnt_q == ($clog2(icache_pkg::beats_per_line))'(
                     icache_pkg::beats_per_line - 1);

  assign lookup_addr_o = addr_q;
  // one fetch in flight, new address only when idle
  assign fetch_ready_o = state_q == icache_pkg::st_idle;

  // request goes out in the lookup cycle itself
  // held until the last beat, then dropped
  assign mem_req_valid_o = ((state_q == icache_pkg::st_lookup) && (uncached || !hit_i)) ||
                           ((state_q == icache_pkg::st_refill) && !done_q) ||
                           ((state_q == icache_pkg::st_uncached) && !done_q);

  // device word at its exact address, lines from their first byte
  assign mem_req_o.addr = uncached ? addr_q :
                          {addr_q[icache_pkg::addr_w-1:icache_pkg::line_off_w],
                           icache_pkg::line_off_w'(0)};
  assign mem_req_o.len = uncached ? 8'd0 : 8'(icache_pkg::beats_per_line - 1);

  // beats go straight into the line array
  assign beat_we_o = (state_q == icache_pkg::st_refill) && mem_beat_valid_i && !done_q;
  assign beat_idx_o = beat_cnt_q;
  // tag written one cycle after the last beat
  assign tag_we_o = (state_q == icache_pkg::st_refill) && done_q;

  // single cycle pulse, no stall from the cpu
  assign rsp_valid_o = ((state_q == icache_pkg::st_lookup) && !uncached && hit_i) ||
                       ((state_q == icache_pkg::st_uncached) && done_q);
  assign src_o = (state_q == icache_pkg::st_uncached) ? icache_pkg::src_uncached :
                                                        icache_pkg::src_cache;
  assign uncached_word_o = word_q;

  // fetch state machine
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= icache_pkg::st_idle;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      case (state_q)
        icache_pkg::st_idle: begin
          if (fetch_valid_i) begin
            state_q <= icache_pkg::st_lookup;
          end
        end
        icache_pkg::st_lookup: begin
          // fresh count for the coming burst
          beat_cnt_q <= '0;
          done_q     <= 1'b0;
          if (uncached) begin
            state_q <= icache_pkg::st_uncached;
          end else if (hit_i) begin
            state_q <= icache_pkg::st_idle;
          end else begin
            state_q <= icache_pkg::st_refill;
          end
        end
        icache_pkg::st_refill: begin
          if (done_q) begin
            // tag lands now, lookup again and hit next cycle
            state_q <= icache_pkg::st_lookup;
            done_q  <= 1'b0;
          end else if (mem_beat_valid_i) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (last_beat) begin
              done_q <= 1'b1;
            end
          end
        end
        icache_pkg::st_uncached: begin
          if (done_q) begin
            // response pulse is this cycle
            state_q <= icache_pkg::st_idle;
            done_q  <= 1'b0;
          end else if (mem_beat_valid_i) begin
            done_q <= 1'b1;
          end
        end
        default: begin
          state_q <= icache_pkg::st_idle;
        end
      endcase
    end
  end

  // address capture on acceptance
  always_ff @(posedge clk) begin
    if (fetch_valid_i && fetch_ready_o) begin
      addr_q <= fetch_addr_i;
    end
  end

  // single beat of an uncached read
  always_ff @(posedge clk) begin
    if ((state_q == icache_pkg::st_uncached) && mem_beat_valid_i && !done_q) begin
      word_q <= mem_beat_i.data;
    end
  end

endmodule

/* verilog/icache_data_store.sv */
`timescale 1ns/10ps

module icache_data_store #(
  parameter int num_lines = 128
) (
  input  logic                                          clk,
  input  logic [icache_pkg::addr_w-1:0]                 lookup_addr_i,
  input  logic                                          beat_we_i,
  input  logic [$clog2(icache_pkg::beats_per_line)-1:0] beat_idx_i,
  input  icache_pkg::mem_beat_t                         beat_i,
  output logic [icache_pkg::line_w-1:0]                 line_o
);

  // index width follows from the line count
  localparam int idx_w = $clog2(num_lines);

  // line index of the current fetch
  logic [idx_w-1:0] idx;

  // line array, one full line per index
  logic [icache_pkg::line_w-1:0] line_mem [num_lines];

  // same index bits as the tag store
  assign idx = lookup_addr_i[icache_pkg::line_off_w +: idx_w];

  // whole indexed line, read without a clock
  // the aligner picks the halfword from it
  assign line_o = line_mem[idx];

  // beat write
  // beat n of the burst lands in word slot n of the line
  // slot 0 holds the lowest addressed word
  always_ff @(posedge clk) begin
    if (beat_we_i) begin
      line_mem[idx][beat_idx_i*icache_pkg::beat_w +: icache_pkg::beat_w] <= beat_i.data;
    end
  end

endmodule

/* verilog/icache_tag_store.sv */
`timescale 1ns/10ps

module icache_tag_store #(
  parameter int num_lines = 128
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [icache_pkg::addr_w-1:0] lookup_addr_i,
  input  logic                          tag_we_i,
  output logic                          hit_o
);

  // index and tag widths follow from the line count
  localparam int idx_w = $clog2(num_lines);
  localparam int tag_w = icache_pkg::addr_w - icache_pkg::line_off_w - idx_w;

  // address fields
  logic [idx_w-1:0] idx;
  logic [tag_w-1:0] tag;

  // one tag and one valid bit per line
  logic [tag_w-1:0] tag_mem [num_lines];
  logic [num_lines-1:0] valid_q;

  // index sits right above the line offset
  assign idx = lookup_addr_i[icache_pkg::line_off_w +: idx_w];
  // tag takes the remaining upper bits
  assign tag = lookup_addr_i[icache_pkg::addr_w-1 -: tag_w];

  // combinational compare on the indexed entry
  assign hit_o = valid_q[idx] && (tag_mem[idx] == tag);

  // valid bits, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      // line becomes valid once the refill is complete
      valid_q[idx] <= 1'b1;
    end
  end

  // tag array
  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_mem[idx] <= tag;
    end
  end

endmodule

/* verilog/icache_pkg.sv */
package icache_pkg;

  // fetch address and line geometry
  localparam int addr_w = 32;
  // 64 byte lines
  localparam int line_off_w = 6;

  // memory side, one 32 bit word per beat
  localparam int beat_w = 32;
  localparam int beats_per_line = 16;
  // whole line as seen by the aligner
  localparam int line_w = beats_per_line * beat_w;

  // device region, fetched word by word and never cached
  // top nibble 4'h1 selects it
  localparam logic [addr_w-1:0] uncached_base = 32'h1000_0000;
  localparam logic [addr_w-1:0] uncached_mask = 32'hf000_0000;

  // read request toward memory
  // len counts beats minus one, as on the burst bus
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [7:0]        len;
  } mem_req_t;

  // one returned data beat
  typedef struct packed {
    logic [beat_w-1:0] data;
  } mem_beat_t;

  // where the returned instruction comes from
  typedef enum logic {
    src_cache,
    src_uncached
  } fetch_src_e;

  // fetch controller states
  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_refill,
    st_uncached
  } refill_state_e;

endpackage
